// File: list.f
+incdir+verilog
+incdir+verif
verilog/outrun_cfg_pkg.sv
verilog/dl_bus_if.sv
verilog/dl_classify.sv
verilog/dl_commit.sv
verilog/tbl_ram.sv
verilog/rom_fetch_dec.sv
verilog/status_mux.sv
verilog/outrun_cfg_top.sv
verif/tb_outrun_cfg.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_outrun_cfg -f list.f -o sim_outrun

./obj_dir/sim_outrun > sim.log
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    exit 1
fi

// File: verif/tb_outrun_model.svh
// Reference model for the configuration block testbench
// Shadow ROM and key tables, expected decoder setup, expected
// decrypted word and expected status byte

`ifndef TB_OUTRUN_MODEL_SVH
`define TB_OUTRUN_MODEL_SVH

logic [15:0] shadow_rom [0:(1<<`ROM_AW)-1];
logic [7:0]  shadow_key [0:(1<<`ROM_AW)-1];
logic        exp_dec_type;
logic        exp_fd1089;
logic        exp_fd1094;
logic [1:0]  exp_game_id;
logic [31:0] rom_words_written;
logic [31:0] reads_issued;
// Even ROM byte not yet paired
logic        pend_vld;
logic [7:0]  pend_hi;
logic [21:0] pend_addr;

task automatic clear_model();
    exp_dec_type      = 1'b0;
    exp_fd1089        = 1'b0;
    exp_fd1094        = 1'b0;
    exp_game_id       = 2'd0;
    rom_words_written = 32'd0;
    reads_issued      = 32'd0;
    pend_vld          = 1'b0;
    pend_hi           = 8'h00;
    pend_addr         = 22'd0;
endtask

// Follow one download byte through the region rules
task automatic apply_byte(input logic hdr, input logic [21:0] addr, input logic [7:0] data);
    logic [21:0] off;
    off = addr - `KEY_BASE;
    if (hdr) begin
        if (addr == 22'd0) begin
            exp_dec_type = data[0];
            exp_fd1089   = data[1];
            exp_fd1094   = data[2];
        end else if (addr == 22'd1) begin
            exp_game_id = data[1:0];
        end
    end else if (addr >= `KEY_BASE && addr < (`KEY_BASE + 22'h2000)) begin
        shadow_key[off[12:0]] = data;
    end else if (addr < 22'h004000) begin
        if (!addr[0]) begin
            pend_vld  = 1'b1;
            pend_hi   = data;
            pend_addr = addr;
        end else if (pend_vld && pend_addr[13:1] == addr[13:1]) begin
            shadow_rom[addr[13:1]] = {pend_hi, data};
            pend_vld               = 1'b0;
            rom_words_written      = rom_words_written + 32'd1;
        end
    end
endtask

function automatic logic [15:0] expected_word(input logic [`ROM_AW-1:0] adr);
    logic [7:0]  k;
    logic [15:0] w;
    k = shadow_key[adr];
    w = shadow_rom[adr];
    if (!(exp_fd1089 || exp_fd1094)) begin
        return w;
    end else if (!exp_dec_type) begin
        return w ^ {k, k};
    end
    // Type 1 flips the key in the low byte
    return w ^ {k, ~k};
endfunction

function automatic logic [7:0] expected_status(input logic [1:0] page);
    case (page)
        2'd0:    return {3'b000, exp_game_id, exp_fd1094, exp_fd1089, exp_dec_type};
        2'd1:    return {6'd0, exp_game_id};
        2'd2:    return rom_words_written[7:0];
        default: return reads_issued[7:0];
    endcase
endfunction

`endif

// File: verif/tb_outrun_cfg.sv
// Testbench for the outrun configuration and decryption block
// Downloads ROM words, key bytes and header settings, then reads the
// ROM back over Wishbone and checks data, protocol and status pages

`timescale 1ns/1ps
`default_nettype none

`include "outrun_cfg_defs.svh"

module tb_outrun_cfg;

    localparam int ack_timeout = 20;

    logic                clk;
    logic                arst_n;
    logic                prog_we;
    logic                prog_header;
    logic [`PROG_AW-1:0] prog_addr;
    logic [7:0]          prog_data;
    logic                wb_cyc;
    logic                wb_stb;
    logic [`ROM_AW-1:0]  wb_adr;
    logic [15:0]         wb_dat_o;
    logic                wb_ack;
    logic [`ST_AW-1:0]   st_addr;
    logic [7:0]          st_dout;

    int                  errors;
    int                  errors_at_start;
    int                  checks;
    int                  tests_run;
    int                  tests_failed;
    logic [31:0]         ack_rises;
    logic                ack_prev;
    logic [`ROM_AW-1:0]  cur_adr;
    logic [`ROM_AW-1:0]  word_list [0:63];

    `include "tb_outrun_model.svh"

    outrun_cfg_top u_outrun_cfg_top (.*);

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Each new acknowledge against the model
    always @(negedge clk) begin
        if (arst_n && wb_ack && !ack_prev) begin
            ack_rises = ack_rises + 32'd1;
            check_value("wb_dat_o", wb_dat_o, expected_word(cur_adr));
        end
        ack_prev = wb_ack;
    end

    task automatic send_byte(input logic hdr, input logic [21:0] addr, input logic [7:0] data);
        @(posedge clk);
        prog_we     <= 1'b1;
        prog_header <= hdr;
        prog_addr   <= addr;
        prog_data   <= data;
        apply_byte(hdr, addr, data);
    endtask

    task automatic send_word(input logic [`ROM_AW-1:0] widx, input logic [15:0] w);
        send_byte(1'b0, {8'd0, widx, 1'b0}, w[15:8]);
        send_byte(1'b0, {8'd0, widx, 1'b1}, w[7:0]);
    endtask

    task automatic send_key(input logic [`ROM_AW-1:0] widx, input logic [7:0] k);
        send_byte(1'b0, `KEY_BASE + {9'd0, widx}, k);
    endtask

    // Stream off and let the last byte reach the tables and status
    task automatic dl_idle();
        @(posedge clk);
        prog_we     <= 1'b0;
        prog_header <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    // Wishbone classic read that holds stb for extra cycles after the ack
    task automatic wb_read(input logic [`ROM_AW-1:0] adr, input logic [1:0] hold);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc       <= 1'b1;
        wb_stb       <= 1'b1;
        wb_adr       <= adr;
        cur_adr      = adr;
        reads_issued = reads_issued + 32'd1;
        @(negedge clk);
        while (!wb_ack && waited < ack_timeout) begin
            waited++;
            @(negedge clk);
        end
        if (!wb_ack) begin
            $display("Read of word %h got no acknowledge within %0d cycles", adr, ack_timeout);
            errors++;
        end
        repeat (hold) begin
            @(negedge clk);
            check_value("wb_ack", {15'd0, wb_ack}, 16'd1);
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        // Ack drops one cycle after stb
        repeat (2) @(negedge clk);
        check_value("wb_ack", {15'd0, wb_ack}, 16'd0);
        check_value("ack count", ack_rises[15:0], reads_issued[15:0]);
    endtask

    task automatic read_list();
        for (int i = 0; i < 64; i++) begin
            wb_read(word_list[i], 2'd0);
        end
    endtask

    task automatic check_status(input logic [1:0] page);
        logic [31:0] r;
        r = $urandom;
        @(posedge clk);
        st_addr <= {page, r[5:0]};
        repeat (2) @(negedge clk);
        check_value("st_dout", {8'h00, st_dout}, {8'h00, expected_status(page)});
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("Test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL with %0d errors", tests_run, name,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        logic [31:0]        r;
        logic [`ROM_AW-1:0] widx;
        r = $urandom(93860);
        clk             = 1'b0;
        arst_n          <= 1'b0;
        prog_we         <= 1'b0;
        prog_header     <= 1'b0;
        prog_addr       <= '0;
        prog_data       <= 8'h00;
        wb_cyc          <= 1'b0;
        wb_stb          <= 1'b0;
        wb_adr          <= '0;
        st_addr         <= '0;
        errors          = 0;
        errors_at_start = 0;
        checks          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        ack_rises       = 32'd0;
        ack_prev        = 1'b0;
        cur_adr         = '0;
        clear_model();
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("wb_ack", {15'd0, wb_ack}, 16'd0);
        check_value("st_dout", {8'h00, st_dout}, 16'd0);
        finish_test("reset values");

        // Decoder still off, words come back plain
        for (int i = 0; i < 64; i++) begin
            r = $urandom;
            word_list[i] = r[12:0];
            send_word(r[12:0], r[28:13]);
            r = $urandom;
            send_key(word_list[i], r[7:0]);
        end
        dl_idle();
        read_list();
        finish_test("plain ROM reads");

        r = $urandom;
        send_byte(1'b1, 22'd0, 8'h02);
        send_byte(1'b1, 22'd1, {6'd0, r[1:0]});
        dl_idle();
        read_list();
        finish_test("fd1089 type 0 decrypt");

        r = $urandom;
        send_byte(1'b1, 22'd0, 8'h05);
        send_byte(1'b1, 22'd1, {6'd0, r[1:0]});
        dl_idle();
        read_list();
        finish_test("fd1094 type 1 decrypt");

        check_status(2'd0);
        check_status(2'd1);
        check_status(2'd2);
        check_status(2'd3);
        finish_test("status pages");

        // A word in the gap above the ROM and a key byte past the key
        // table, both aimed at listed words, unused header addresses
        // with data unlike the current setup and a lone even ROM byte
        r = $urandom;
        send_byte(1'b0, 22'h004000 + {8'd0, word_list[1], 1'b0}, r[20:13]);
        send_byte(1'b0, 22'h004000 + {8'd0, word_list[1], 1'b1}, r[28:21]);
        send_byte(1'b0, 22'h102000 + {9'd0, word_list[2]}, r[28:21]);
        send_byte(1'b1, 22'd2 + {19'd0, r[2:0]}, {r[31:27], 1'b0, ~exp_game_id});
        send_byte(1'b0, {8'd0, word_list[0], 1'b0}, ~r[7:0]);
        dl_idle();
        check_status(2'd0);
        check_status(2'd1);
        check_status(2'd2);
        for (int i = 0; i < 8; i++) begin
            wb_read(word_list[i], 2'd0);
        end
        r = $urandom;
        widx = r[12:0];
        send_word(widx, r[28:13]);
        send_key(widx, r[31:24]);
        dl_idle();
        wb_read(widx, 2'd0);
        check_status(2'd2);
        finish_test("dropped and partial bytes");

        for (int i = 0; i < 32; i++) begin
            r = $urandom;
            repeat (r[1:0]) @(posedge clk);
            wb_read(word_list[r[10:5]], r[3:2]);
        end
        check_status(2'd3);
        finish_test("Wishbone back-to-back");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/dl_bus_if.sv
// Download item bus
// One classified item per valid cycle, from the classify stage
// to the commit stage

`timescale 1ns/1ps
`default_nettype none

`include "outrun_cfg_defs.svh"

interface dl_bus_if
    import outrun_cfg_pkg::*;
();
    logic               valid;
    dl_region_t         region;
    // Byte address for key/header, word address for ROM
    logic [`PROG_AW-1:0] addr;
    // Key and header bytes sit in the low byte
    rom_word_t          data;

    modport src (output valid, region, addr, data);
    modport dst (input  valid, region, addr, data);
endinterface

`default_nettype wire

// File: verilog/dl_classify.sv
// Download classifier, first download stage
// Tags each strobed byte as header, key or ROM and drops the rest.
// ROM bytes are paired here, so only complete 16-bit words move on

`timescale 1ns/1ps
`default_nettype none

`include "outrun_cfg_defs.svh"

module dl_classify
    import outrun_cfg_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                prog_we,
    input  wire logic                prog_header,
    input  wire logic [`PROG_AW-1:0] prog_addr,
    input  wire logic [7:0]          prog_data,
    dl_bus_if.src                    dl
);

    localparam logic [`PROG_AW-1:0] key_base = `KEY_BASE;

    dl_region_t          region_d;
    logic [`PROG_AW-1:0] addr_d;

    // Registered byte with its region
    logic                s1_vld;
    dl_region_t          s1_region;
    logic [`PROG_AW-1:0] s1_addr;
    logic [7:0]          s1_data;

    // Even ROM byte waiting for its partner
    logic                hold_vld;
    logic [7:0]          hold_hi;
    logic [`ROM_AW-1:0]  hold_waddr;

    always_comb begin
        region_d = DL_NONE;
        addr_d   = prog_addr;
        if (prog_header) begin
            region_d = DL_HEADER;
        end else if (prog_addr[`PROG_AW-1:`ROM_AW] == key_base[`PROG_AW-1:`ROM_AW]) begin
            region_d = DL_KEY;
            addr_d   = prog_addr - key_base;
        end else if (prog_addr[`PROG_AW-1:`ROM_AW+1] == '0) begin
            region_d = DL_ROM;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_vld   <= 1'b0;
            dl.valid <= 1'b0;
            hold_vld <= 1'b0;
        end else begin
            s1_vld   <= prog_we && (region_d != DL_NONE);
            dl.valid <= 1'b0;
            if (s1_vld) begin
                if (s1_region != DL_ROM) begin
                    dl.valid <= 1'b1;
                end else if (!s1_addr[0]) begin
                    hold_vld <= 1'b1;
                end else if (hold_vld && hold_waddr == s1_addr[`ROM_AW:1]) begin
                    // Odd byte closes the word
                    dl.valid <= 1'b1;
                    hold_vld <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_region <= region_d;
        s1_addr   <= addr_d;
        s1_data   <= prog_data;
        if (s1_vld && s1_region == DL_ROM && !s1_addr[0]) begin
            hold_hi    <= s1_data;
            hold_waddr <= s1_addr[`ROM_AW:1];
        end
        dl.region <= s1_region;
        if (s1_region == DL_ROM) begin
            dl.addr <= s1_addr >> 1;
            dl.data <= {hold_hi, s1_data};
        end else begin
            dl.addr <= s1_addr;
            dl.data <= {8'h00, s1_data};
        end
    end

endmodule

`default_nettype wire

// File: verilog/dl_commit.sv
// Download commit, second download stage
// Latches the decoder configuration from header bytes, turns key and
// ROM items into table writes and counts the ROM words written

`timescale 1ns/1ps
`default_nettype none

`include "outrun_cfg_defs.svh"

module dl_commit
    import outrun_cfg_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               arst_n,
    dl_bus_if.dst                   dl,
    output dec_cfg_t                cfg,
    output logic                    key_we,
    output logic [`ROM_AW-1:0]      key_waddr,
    output key_byte_t               key_wdata,
    output logic                    rom_we,
    output logic [`ROM_AW-1:0]      rom_waddr,
    output rom_word_t               rom_wdata,
    output logic [7:0]              rom_words
);

    logic hdr_vld;

    assign hdr_vld = dl.valid && dl.region == DL_HEADER;

    // Table writes land on the edge after the item shows up
    assign key_we    = dl.valid && dl.region == DL_KEY;
    assign key_waddr = dl.addr[`ROM_AW-1:0];
    assign key_wdata = dl.data[7:0];

    assign rom_we    = dl.valid && dl.region == DL_ROM;
    assign rom_waddr = dl.addr[`ROM_AW-1:0];
    assign rom_wdata = dl.data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg       <= '0;
            rom_words <= 8'd0;
        end else begin
            if (hdr_vld && dl.addr == '0) begin
                cfg.dec_type  <= dl.data[0];
                cfg.fd1089_en <= dl.data[1];
                cfg.fd1094_en <= dl.data[2];
            end
            if (hdr_vld && dl.addr == `PROG_AW'd1) begin
                cfg.game_id <= dl.data[1:0];
            end
            // Wraps at 256
            if (rom_we) begin
                rom_words <= rom_words + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/outrun_cfg_defs.svh
// Outrun configuration block, shared sizes
// Address widths of the download stream, the ROM and key tables and
// the status port, plus the base of the key region

`ifndef OUTRUN_CFG_DEFS_SVH
`define OUTRUN_CFG_DEFS_SVH

// Download byte address width
`define PROG_AW 22

// ROM word address, also the key table index
`define ROM_AW 13

// Key region start, 8 KB long
// ROM region is the first 16 KB of the stream
`define KEY_BASE 22'h100000

// Status select width, top two bits pick the page
`define ST_AW 8

`endif

// File: verilog/outrun_cfg_pkg.sv
// Outrun configuration package
// Download region tags, decoder configuration and table payload types

`default_nettype none

package outrun_cfg_pkg;

    // Where a download byte goes
    typedef enum logic [1:0] {
        DL_NONE   = 2'd0,
        DL_HEADER = 2'd1,
        DL_KEY    = 2'd2,
        DL_ROM    = 2'd3
    } dl_region_t;

    // Decoder setup from the header
    // Top-down order matches status page 0
    typedef struct packed {
        logic [1:0] game_id;
        logic       fd1094_en;
        logic       fd1089_en;
        logic       dec_type;
    } dec_cfg_t;

    // Program ROM word
    typedef logic [15:0] rom_word_t;

    // One byte of the decryption key
    typedef logic [7:0] key_byte_t;

endpackage

`default_nettype wire

// File: verilog/outrun_cfg_top.sv
// Outrun configuration and decryption block, top level
// Download pipeline fills the decoder setup, key table and program
// ROM. The main CPU reads the ROM through a decrypting Wishbone
// slave, and a status port reports setup and activity

`timescale 1ns/1ps
`default_nettype none

`include "outrun_cfg_defs.svh"

module outrun_cfg_top
    import outrun_cfg_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                arst_n,
    // Download stream
    input  wire logic                prog_we,
    input  wire logic                prog_header,
    input  wire logic [`PROG_AW-1:0] prog_addr,
    input  wire logic [7:0]          prog_data,
    // Main CPU ROM port
    input  wire logic                wb_cyc,
    input  wire logic                wb_stb,
    input  wire logic [`ROM_AW-1:0]  wb_adr,
    output logic [15:0]              wb_dat_o,
    output logic                     wb_ack,
    // Status readback
    input  wire logic [`ST_AW-1:0]   st_addr,
    output logic [7:0]               st_dout
);

    dec_cfg_t           cfg;
    logic               key_we;
    logic [`ROM_AW-1:0] key_waddr;
    key_byte_t          key_wdata;
    logic               rom_we;
    logic [`ROM_AW-1:0] rom_waddr;
    rom_word_t          rom_wdata;
    logic [7:0]         rom_words;
    logic [`ROM_AW-1:0] rom_raddr;
    logic [`ROM_AW-1:0] key_raddr;
    rom_word_t          rom_rdata;
    key_byte_t          key_rdata;
    logic [7:0]         fetch_count;

    dl_bus_if u_dl_bus ();

    dl_classify u_dl_classify (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .prog_we     ( prog_we     ),
        .prog_header ( prog_header ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .dl          ( u_dl_bus    )
    );

    dl_commit u_dl_commit (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .dl        ( u_dl_bus  ),
        .cfg       ( cfg       ),
        .key_we    ( key_we    ),
        .key_waddr ( key_waddr ),
        .key_wdata ( key_wdata ),
        .rom_we    ( rom_we    ),
        .rom_waddr ( rom_waddr ),
        .rom_wdata ( rom_wdata ),
        .rom_words ( rom_words )
    );

    // Program ROM, 8K words
    tbl_ram #(.word_t(rom_word_t), .aw(`ROM_AW)) u_rom_ram (
        .clk   ( clk       ),
        .we    ( rom_we    ),
        .waddr ( rom_waddr ),
        .wdata ( rom_wdata ),
        .raddr ( rom_raddr ),
        .rdata ( rom_rdata )
    );

    // Key table, one byte per ROM word address
    tbl_ram #(.word_t(key_byte_t), .aw(`ROM_AW)) u_key_ram (
        .clk   ( clk       ),
        .we    ( key_we    ),
        .waddr ( key_waddr ),
        .wdata ( key_wdata ),
        .raddr ( key_raddr ),
        .rdata ( key_rdata )
    );

    rom_fetch_dec u_rom_fetch_dec (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .wb_cyc      ( wb_cyc      ),
        .wb_stb      ( wb_stb      ),
        .wb_adr      ( wb_adr      ),
        .cfg         ( cfg         ),
        .rom_raddr   ( rom_raddr   ),
        .key_raddr   ( key_raddr   ),
        .rom_rdata   ( rom_rdata   ),
        .key_rdata   ( key_rdata   ),
        .wb_dat_o    ( wb_dat_o    ),
        .wb_ack      ( wb_ack      ),
        .fetch_count ( fetch_count )
    );

    status_mux u_status_mux (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .st_addr     ( st_addr     ),
        .cfg         ( cfg         ),
        .rom_words   ( rom_words   ),
        .fetch_count ( fetch_count ),
        .st_dout     ( st_dout     )
    );

endmodule

`default_nettype wire

// File: verilog/rom_fetch_dec.sv
// Program ROM fetch and decrypt
// Read-only Wishbone classic slave for the main CPU. A request reads
// the ROM word and its key byte, applies the decoder rule and
// acknowledges two cycles later

`timescale 1ns/1ps
`default_nettype none

`include "outrun_cfg_defs.svh"

module rom_fetch_dec
    import outrun_cfg_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              wb_cyc,
    input  wire logic              wb_stb,
    input  wire logic [`ROM_AW-1:0] wb_adr,
    input  wire dec_cfg_t          cfg,
    output logic [`ROM_AW-1:0]     rom_raddr,
    output logic [`ROM_AW-1:0]     key_raddr,
    input  wire rom_word_t         rom_rdata,
    input  wire key_byte_t         key_rdata,
    output rom_word_t              wb_dat_o,
    output logic                   wb_ack,
    output logic [7:0]             fetch_count
);

    logic               req;
    logic               launch;
    logic               s1_vld;
    logic               s2_vld;
    logic [`ROM_AW-1:0] adr_q;
    logic               dec_en;
    rom_word_t          key_mask;
    rom_word_t          dec_word;

    assign req = wb_cyc && wb_stb;

    // One fetch in flight at a time
    assign launch = req && !wb_ack && !s1_vld && !s2_vld;

    // Same word address for both tables
    assign rom_raddr = adr_q;
    assign key_raddr = adr_q;

    assign dec_en   = cfg.fd1089_en | cfg.fd1094_en;
    // Type 1 inverts the key in the low byte
    assign key_mask = cfg.dec_type ? {key_rdata, ~key_rdata} : {key_rdata, key_rdata};
    assign dec_word = dec_en ? (rom_rdata ^ key_mask) : rom_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_vld      <= 1'b0;
            s2_vld      <= 1'b0;
            wb_ack      <= 1'b0;
            fetch_count <= 8'd0;
        end else begin
            s1_vld <= launch;
            s2_vld <= s1_vld;
            if (s2_vld && req) begin
                wb_ack      <= 1'b1;
                fetch_count <= fetch_count + 8'd1;
            end else if (!req) begin
                // Held while the master keeps stb up
                wb_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            adr_q <= wb_adr;
        end
        if (s2_vld) begin
            wb_dat_o <= dec_word;
        end
    end

endmodule

`default_nettype wire

// File: verilog/status_mux.sv
// Status readback
// Registered byte chosen by the top two status address bits:
// configuration, game id, ROM word count or fetch count

`timescale 1ns/1ps
`default_nettype none

`include "outrun_cfg_defs.svh"

module status_mux
    import outrun_cfg_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic [`ST_AW-1:0] st_addr,
    input  wire dec_cfg_t          cfg,
    input  wire logic [7:0]        rom_words,
    input  wire logic [7:0]        fetch_count,
    output logic [7:0]             st_dout
);

    logic [1:0] page;

    assign page = st_addr[`ST_AW-1:`ST_AW-2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_dout <= 8'd0;
        end else begin
            case (page)
                // game_id, fd1094, fd1089, dec_type
                2'd0: st_dout <= {3'b000, cfg};
                2'd1: st_dout <= {6'd0, cfg.game_id};
                2'd2: st_dout <= rom_words;
                default: st_dout <= fetch_count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/tbl_ram.sv
// Generic table memory
// One write port and one read port, both synchronous,
// read data registered. Payload type set per instance

`timescale 1ns/1ps
`default_nettype none

`include "outrun_cfg_defs.svh"

module tbl_ram #(
    parameter type word_t = logic [7:0],
    parameter int  aw     = `ROM_AW
) (
    input  wire logic          clk,
    input  wire logic          we,
    input  wire logic [aw-1:0] waddr,
    input  wire word_t         wdata,
    input  wire logic [aw-1:0] raddr,
    output word_t              rdata
);

    word_t mem [0:(1<<aw)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read of the same address as a write returns the old word
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire
